// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     ?= alu_mdu_iq_tb
RTL_TOP    ?= alu_mdu_iq
FILE_LIST  ?= list.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/alu_mdu_iq.sv ====
// issue queue for the ALU reg-reg and mul-div pipelines, ENTRIES >= 3, 1 to 4 ways
// ready bits at dispatch must already include any writeback of that same cycle
`default_nettype none

module alu_mdu_iq import iq_pkg::*; #(
    parameter int ENTRIES       = 8,
    parameter int DISPATCH_WAYS = 2
) (
    input  logic                                CLK,
    input  logic                                nRST,
    // dispatch by way
    input  logic     [DISPATCH_WAYS-1:0]        dispatch_attempt,
    input  logic     [DISPATCH_WAYS-1:0]        dispatch_is_alu,
    input  logic     [DISPATCH_WAYS-1:0]        dispatch_is_mdu,
    input  op_t      [DISPATCH_WAYS-1:0]        dispatch_op,
    input  pr_t      [DISPATCH_WAYS-1:0]        dispatch_a_pr,
    input  logic     [DISPATCH_WAYS-1:0]        dispatch_a_ready,
    input  pr_t      [DISPATCH_WAYS-1:0]        dispatch_b_pr,
    input  logic     [DISPATCH_WAYS-1:0]        dispatch_b_ready,
    input  pr_t      [DISPATCH_WAYS-1:0]        dispatch_dest_pr,
    input  rob_idx_t [DISPATCH_WAYS-1:0]        dispatch_rob_idx,
    output logic     [DISPATCH_WAYS-1:0]        dispatch_ack,
    // writeback by bank
    input  logic      [BANKS-1:0]               wb_valid,
    input  upper_pr_t [BANKS-1:0]               wb_upper_pr,
    // ALU pipeline
    output logic                                alu_issue_valid,
    output issue_t                              alu_issue,
    input  logic                                alu_issue_ready,
    output logic                                prf_alu_req_a_valid,
    output pr_t                                 prf_alu_req_a_pr,
    output logic                                prf_alu_req_b_valid,
    output pr_t                                 prf_alu_req_b_pr,
    // mul-div pipeline
    output logic                                mdu_issue_valid,
    output issue_t                              mdu_issue,
    input  logic                                mdu_issue_ready,
    output logic                                prf_mdu_req_a_valid,
    output pr_t                                 prf_mdu_req_a_pr,
    output logic                                prf_mdu_req_b_valid,
    output pr_t                                 prf_mdu_req_b_pr
);

    iq_payload_t [DISPATCH_WAYS-1:0] dispatch_payload;

    logic        [ENTRIES-1:0]      valid_alu;
    logic        [ENTRIES-1:0]      valid_mdu;
    iq_payload_t [ENTRIES-1:0]      payload;
    logic        [ENTRIES-1:0]      free_mask;
    logic        [ENTRIES-1:0]      a_forward;
    logic        [ENTRIES-1:0]      b_forward;
    logic        [ENTRIES-1:0]      alu_take_mask;
    logic        [ENTRIES-1:0]      mdu_take_mask;
    logic        [ENTRIES-1:0][1:0] shift_amt;
    logic        [ENTRIES-1:0]      fill_valid;
    logic        [ENTRIES-1:0]      fill_is_alu;
    logic        [ENTRIES-1:0]      fill_is_mdu;
    iq_payload_t [ENTRIES-1:0]      fill_payload;

    for (genvar w = 0; w < DISPATCH_WAYS; w++) begin : g_pack
        assign dispatch_payload[w] = '{
            op:      dispatch_op[w],
            a_pr:    dispatch_a_pr[w],
            a_ready: dispatch_a_ready[w],
            b_pr:    dispatch_b_pr[w],
            b_ready: dispatch_b_ready[w],
            dest_pr: dispatch_dest_pr[w],
            rob_idx: dispatch_rob_idx[w]
        };
    end

    dispatch_alloc #(.ENTRIES(ENTRIES), .DISPATCH_WAYS(DISPATCH_WAYS)) alloc (
        .CLK(CLK), .nRST(nRST),
        .dispatch_attempt(dispatch_attempt), .dispatch_is_alu(dispatch_is_alu),
        .dispatch_is_mdu(dispatch_is_mdu), .dispatch_payload(dispatch_payload),
        .free_mask(free_mask), .dispatch_ack(dispatch_ack),
        .fill_valid(fill_valid), .fill_is_alu(fill_is_alu),
        .fill_is_mdu(fill_is_mdu), .fill_payload(fill_payload)
    );

    operand_wakeup #(.ENTRIES(ENTRIES), .DISPATCH_WAYS(DISPATCH_WAYS)) wakeup (
        .payload(payload), .wb_valid(wb_valid), .wb_upper_pr(wb_upper_pr),
        .a_forward(a_forward), .b_forward(b_forward)
    );

    issue_select #(.ENTRIES(ENTRIES), .DISPATCH_WAYS(DISPATCH_WAYS)) alu_select (
        .kind_valid(valid_alu), .payload(payload),
        .a_forward(a_forward), .b_forward(b_forward), .ready(alu_issue_ready),
        .issue_valid(alu_issue_valid), .issue(alu_issue),
        .req_a_valid(prf_alu_req_a_valid), .req_a_pr(prf_alu_req_a_pr),
        .req_b_valid(prf_alu_req_b_valid), .req_b_pr(prf_alu_req_b_pr),
        .take_mask(alu_take_mask)
    );

    issue_select #(.ENTRIES(ENTRIES), .DISPATCH_WAYS(DISPATCH_WAYS)) mdu_select (
        .kind_valid(valid_mdu), .payload(payload),
        .a_forward(a_forward), .b_forward(b_forward), .ready(mdu_issue_ready),
        .issue_valid(mdu_issue_valid), .issue(mdu_issue),
        .req_a_valid(prf_mdu_req_a_valid), .req_a_pr(prf_mdu_req_a_pr),
        .req_b_valid(prf_mdu_req_b_valid), .req_b_pr(prf_mdu_req_b_pr),
        .take_mask(mdu_take_mask)
    );

    collapse_ctrl #(.ENTRIES(ENTRIES), .DISPATCH_WAYS(DISPATCH_WAYS)) collapse (
        .CLK(CLK), .nRST(nRST),
        .alu_take_mask(alu_take_mask), .mdu_take_mask(mdu_take_mask),
        .shift_amt(shift_amt)
    );

    entry_array #(.ENTRIES(ENTRIES), .DISPATCH_WAYS(DISPATCH_WAYS)) entries (
        .CLK(CLK), .nRST(nRST), .shift_amt(shift_amt),
        .fill_valid(fill_valid), .fill_is_alu(fill_is_alu),
        .fill_is_mdu(fill_is_mdu), .fill_payload(fill_payload),
        .a_forward(a_forward), .b_forward(b_forward),
        .valid_alu(valid_alu), .valid_mdu(valid_mdu),
        .payload(payload), .free_mask(free_mask)
    );

endmodule

`default_nettype wire

// ==== hdl/collapse_ctrl.sv ====
// per-entry collapse distance from the two take masks
// the two picks are different entries since an entry has exactly one kind
`default_nettype none

module collapse_ctrl import iq_pkg::*; #(
    parameter int ENTRIES       = 8,
    parameter int DISPATCH_WAYS = 2
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic [ENTRIES-1:0]          alu_take_mask,
    input  logic [ENTRIES-1:0]          mdu_take_mask,
    output logic [ENTRIES-1:0][1:0]     shift_amt
);

    logic [ENTRIES-1:0] any_take;
    logic [ENTRIES-1:0] both_above;

    if (ENTRIES < 3 || DISPATCH_WAYS < 1 || DISPATCH_WAYS > 4) begin : g_param_check
        $error("collapse_ctrl needs ENTRIES >= 3 and 1 to 4 dispatch ways");
    end

    assign any_take = alu_take_mask | mdu_take_mask;

    // both picks at or below the source means a jump of two
    // top entry counts its own take bits
    assign both_above = {alu_take_mask[ENTRIES-1] & mdu_take_mask[ENTRIES-1],
                         alu_take_mask[ENTRIES-1:1] & mdu_take_mask[ENTRIES-1:1]};

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            if (!any_take[i]) begin
                shift_amt[i] = 2'd0;
            end else if (both_above[i]) begin
                shift_amt[i] = 2'd2;
            end else begin
                shift_amt[i] = 2'd1;
            end
        end
    end

    // --------------------
    // checks

    // take masks run from the pick up to the top entry
    a_alu_run: assert property (@(posedge CLK) disable iff (~nRST)
        ((alu_take_mask << 1) & ~alu_take_mask) == '0);
    a_mdu_run: assert property (@(posedge CLK) disable iff (~nRST)
        ((mdu_take_mask << 1) & ~mdu_take_mask) == '0);

    for (genvar i = 0; i < ENTRIES - 1; i++) begin : g_mono
        a_shift_mono: assert property (@(posedge CLK) disable iff (~nRST)
            shift_amt[i+1] >= shift_amt[i]);
    end

endmodule

`default_nettype wire

// ==== hdl/dispatch_alloc.sv ====
// lowest free entry per way, lower ways first
// a way without attempt takes no entry and passes the free mask on unchanged
`default_nettype none

module dispatch_alloc import iq_pkg::*; #(
    parameter int ENTRIES       = 8,
    parameter int DISPATCH_WAYS = 2
) (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic        [DISPATCH_WAYS-1:0]         dispatch_attempt,
    input  logic        [DISPATCH_WAYS-1:0]         dispatch_is_alu,
    input  logic        [DISPATCH_WAYS-1:0]         dispatch_is_mdu,
    input  iq_payload_t [DISPATCH_WAYS-1:0]         dispatch_payload,
    input  logic        [ENTRIES-1:0]               free_mask,
    output logic        [DISPATCH_WAYS-1:0]         dispatch_ack,
    output logic        [ENTRIES-1:0]               fill_valid,
    output logic        [ENTRIES-1:0]               fill_is_alu,
    output logic        [ENTRIES-1:0]               fill_is_mdu,
    output iq_payload_t [ENTRIES-1:0]               fill_payload
);

    logic [DISPATCH_WAYS-1:0][ENTRIES-1:0] open_mask;
    logic [DISPATCH_WAYS-1:0][ENTRIES-1:0] pick;

    // --------------------
    // cascaded picks
    for (genvar w = 0; w < DISPATCH_WAYS; w++) begin : g_way
        if (w == 0) begin : g_first
            assign open_mask[w] = free_mask;
        end else begin : g_next
            assign open_mask[w] = open_mask[w-1] & ~pick[w-1];
        end

        // isolate lowest open bit
        assign pick[w] = dispatch_attempt[w] ? (open_mask[w] & (~open_mask[w] + 1'b1)) : '0;
        assign dispatch_ack[w] = |pick[w];
    end

    // --------------------
    // route way payloads to their entries
    always_comb begin
        fill_valid   = '0;
        fill_is_alu  = '0;
        fill_is_mdu  = '0;
        fill_payload = '0;
        for (int e = 0; e < ENTRIES; e++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                if (pick[w][e]) begin
                    fill_valid[e]   = 1'b1;
                    fill_is_alu[e]  = dispatch_is_alu[w];
                    fill_is_mdu[e]  = dispatch_is_mdu[w];
                    fill_payload[e] = dispatch_payload[w];
                end
            end
        end
    end

    // two ways landing on one entry would lose an acked op
    a_unique_fill: assert property (@(posedge CLK) disable iff (~nRST)
        $countones(fill_valid) == $countones(dispatch_ack));

endmodule

`default_nettype wire

// ==== hdl/entry_array.sv ====
// collapsing entry storage, index 0 is oldest
// an empty source slot supplies that slot's dispatch fill
`default_nettype none

module entry_array import iq_pkg::*; #(
    parameter int ENTRIES       = 8,
    parameter int DISPATCH_WAYS = 2
) (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic        [ENTRIES-1:0][1:0]  shift_amt,
    input  logic        [ENTRIES-1:0]       fill_valid,
    input  logic        [ENTRIES-1:0]       fill_is_alu,
    input  logic        [ENTRIES-1:0]       fill_is_mdu,
    input  iq_payload_t [ENTRIES-1:0]       fill_payload,
    input  logic        [ENTRIES-1:0]       a_forward,
    input  logic        [ENTRIES-1:0]       b_forward,
    output logic        [ENTRIES-1:0]       valid_alu,
    output logic        [ENTRIES-1:0]       valid_mdu,
    output iq_payload_t [ENTRIES-1:0]       payload,
    output logic        [ENTRIES-1:0]       free_mask
);

    logic        [ENTRIES-1:0] next_alu;
    logic        [ENTRIES-1:0] next_mdu;
    iq_payload_t [ENTRIES-1:0] next_payload;

    assign free_mask = ~(valid_alu | valid_mdu);

    // --------------------
    // next state per entry
    always_comb begin
        int src;
        for (int i = 0; i < ENTRIES; i++) begin
            next_alu[i]     = 1'b0;
            next_mdu[i]     = 1'b0;
            next_payload[i] = payload[i];
            src = i + int'(shift_amt[i]);
            if (src < ENTRIES) begin
                if (valid_alu[src] | valid_mdu[src]) begin
                    next_alu[i]             = valid_alu[src];
                    next_mdu[i]             = valid_mdu[src];
                    next_payload[i]         = payload[src];
                    // wakeup sticks from this edge on
                    next_payload[i].a_ready = payload[src].a_ready | a_forward[src];
                    next_payload[i].b_ready = payload[src].b_ready | b_forward[src];
                end else begin
                    next_alu[i]     = fill_valid[src] & fill_is_alu[src];
                    next_mdu[i]     = fill_valid[src] & fill_is_mdu[src];
                    next_payload[i] = fill_payload[src];
                end
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            valid_alu <= '0;
            valid_mdu <= '0;
        end else begin
            valid_alu <= next_alu;
            valid_mdu <= next_mdu;
        end
    end

    always_ff @(posedge CLK) begin
        payload <= next_payload;
    end

    // --------------------
    // checks

    a_one_kind: assert property (@(posedge CLK) disable iff (~nRST)
        (valid_alu & valid_mdu) == '0);

    a_fill_count: assert property (@(posedge CLK) disable iff (~nRST)
        $countones(fill_valid) <= DISPATCH_WAYS);

endmodule

`default_nettype wire

// ==== hdl/iq_pkg.sv ====
// widths and records shared by the ALU / mul-div issue queue
// a register's bank is its low BANK_W bits, the rest are the upper number
`default_nettype none

package iq_pkg;

    parameter int PR_W   = 6;
    parameter int BANK_W = 2;
    parameter int BANKS  = 1 << BANK_W;
    parameter int ROB_W  = 5;
    parameter int OP_W   = 4;

    typedef logic [PR_W-1:0]        pr_t;
    typedef logic [BANK_W-1:0]      bank_t;
    typedef logic [PR_W-BANK_W-1:0] upper_pr_t;
    typedef logic [ROB_W-1:0]       rob_idx_t;
    typedef logic [OP_W-1:0]        op_t;

    // --------------------
    // stored operation

    typedef struct packed {
        op_t      op;
        pr_t      a_pr;
        logic     a_ready;
        pr_t      b_pr;
        logic     b_ready;
        pr_t      dest_pr;
        rob_idx_t rob_idx;
    } iq_payload_t;

    // --------------------
    // record handed to a pipeline

    typedef struct packed {
        op_t      op;
        logic     a_forward;
        bank_t    a_bank;
        logic     b_forward;
        bank_t    b_bank;
        pr_t      dest_pr;
        rob_idx_t rob_idx;
    } issue_t;

endpackage

`default_nettype wire

// ==== hdl/issue_select.sv ====
// oldest eligible entry of one kind, lowest index wins
// issue_valid never looks at ready; take_mask and requests only on a transfer
`default_nettype none

module issue_select import iq_pkg::*; #(
    parameter int ENTRIES       = 8,
    parameter int DISPATCH_WAYS = 2
) (
    input  logic        [ENTRIES-1:0]   kind_valid,
    input  iq_payload_t [ENTRIES-1:0]   payload,
    input  logic        [ENTRIES-1:0]   a_forward,
    input  logic        [ENTRIES-1:0]   b_forward,
    input  logic                        ready,
    output logic                        issue_valid,
    output issue_t                      issue,
    output logic                        req_a_valid,
    output pr_t                         req_a_pr,
    output logic                        req_b_valid,
    output pr_t                         req_b_pr,
    output logic        [ENTRIES-1:0]   take_mask
);

    logic [ENTRIES-1:0] eligible;
    logic [ENTRIES-1:0] pick;
    logic               transfer;

    if (ENTRIES < 3 || DISPATCH_WAYS < 1 || DISPATCH_WAYS > 4) begin : g_param_check
        $error("issue_select needs ENTRIES >= 3 and 1 to 4 dispatch ways");
    end

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            eligible[i] = kind_valid[i]
                & (payload[i].a_ready | a_forward[i])
                & (payload[i].b_ready | b_forward[i]);
        end
    end

    assign pick        = eligible & (~eligible + 1'b1);
    assign issue_valid = |eligible;
    assign transfer    = issue_valid & ready;

    // picked entry and everything younger moves down
    assign take_mask = transfer ? ~(pick - 1'b1) : '0;

    // --------------------
    // one-hot payload mux
    always_comb begin
        issue    = '0;
        req_a_pr = '0;
        req_b_pr = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (pick[i]) begin
                issue.op        = payload[i].op;
                issue.a_forward = a_forward[i];
                issue.a_bank    = payload[i].a_pr[BANK_W-1:0];
                issue.b_forward = b_forward[i];
                issue.b_bank    = payload[i].b_pr[BANK_W-1:0];
                issue.dest_pr   = payload[i].dest_pr;
                issue.rob_idx   = payload[i].rob_idx;
                req_a_pr        = payload[i].a_pr;
                req_b_pr        = payload[i].b_pr;
            end
        end
    end

    // forwarded operands come from the bypass, not the register file
    assign req_a_valid = transfer & ~issue.a_forward;
    assign req_b_valid = transfer & ~issue.b_forward;

endmodule

`default_nettype wire

// ==== hdl/operand_wakeup.sv ====
// one writeback bus per bank, matched against both sources of every entry
`default_nettype none

module operand_wakeup import iq_pkg::*; #(
    parameter int ENTRIES       = 8,
    parameter int DISPATCH_WAYS = 2
) (
    input  iq_payload_t [ENTRIES-1:0]   payload,
    input  logic        [BANKS-1:0]     wb_valid,
    input  upper_pr_t   [BANKS-1:0]     wb_upper_pr,
    output logic        [ENTRIES-1:0]   a_forward,
    output logic        [ENTRIES-1:0]   b_forward
);

    if (ENTRIES < 3 || DISPATCH_WAYS < 1 || DISPATCH_WAYS > 4) begin : g_param_check
        $error("operand_wakeup needs ENTRIES >= 3 and 1 to 4 dispatch ways");
    end

    always_comb begin
        bank_t a_bank;
        bank_t b_bank;
        for (int i = 0; i < ENTRIES; i++) begin
            a_bank = payload[i].a_pr[BANK_W-1:0];
            b_bank = payload[i].b_pr[BANK_W-1:0];
            // bank picks the bus, upper bits must match
            a_forward[i] = wb_valid[a_bank]
                & (wb_upper_pr[a_bank] == payload[i].a_pr[PR_W-1:BANK_W]);
            b_forward[i] = wb_valid[b_bank]
                & (wb_upper_pr[b_bank] == payload[i].b_pr[PR_W-1:BANK_W]);
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/iq_pkg.sv
hdl/dispatch_alloc.sv
hdl/operand_wakeup.sv
hdl/issue_select.sv
hdl/collapse_ctrl.sv
hdl/entry_array.sv
hdl/alu_mdu_iq.sv
verif/alu_mdu_iq_tb.sv

// ==== verif/alu_mdu_iq_tb.sv ====
// directed tests of the issue queue at default parameters
// expected picks come from an in-order model of the queue contents
`default_nettype none

module alu_mdu_iq_tb import iq_pkg::*; ();

    localparam int ENTRIES     = 8;
    localparam int WAYS        = 2;
    // reset plus the worst case of each test, in cycles
    localparam int TEST_CYCLES = 10 + 18 + 5 + 27 + 22 + 30;
    localparam int WATCHDOG    = TEST_CYCLES * 4 + 200;

    logic                   CLK;
    logic                   nRST;
    logic      [WAYS-1:0]   dispatch_attempt;
    logic      [WAYS-1:0]   dispatch_is_alu;
    logic      [WAYS-1:0]   dispatch_is_mdu;
    op_t       [WAYS-1:0]   dispatch_op;
    pr_t       [WAYS-1:0]   dispatch_a_pr;
    logic      [WAYS-1:0]   dispatch_a_ready;
    pr_t       [WAYS-1:0]   dispatch_b_pr;
    logic      [WAYS-1:0]   dispatch_b_ready;
    pr_t       [WAYS-1:0]   dispatch_dest_pr;
    rob_idx_t  [WAYS-1:0]   dispatch_rob_idx;
    logic      [WAYS-1:0]   dispatch_ack;
    logic      [BANKS-1:0]  wb_valid;
    upper_pr_t [BANKS-1:0]  wb_upper_pr;
    logic                   alu_issue_valid;
    issue_t                 alu_issue;
    logic                   alu_issue_ready;
    logic                   prf_alu_req_a_valid;
    pr_t                    prf_alu_req_a_pr;
    logic                   prf_alu_req_b_valid;
    pr_t                    prf_alu_req_b_pr;
    logic                   mdu_issue_valid;
    issue_t                 mdu_issue;
    logic                   mdu_issue_ready;
    logic                   prf_mdu_req_a_valid;
    pr_t                    prf_mdu_req_a_pr;
    logic                   prf_mdu_req_b_valid;
    pr_t                    prf_mdu_req_b_pr;

    // model of the queue, index 0 oldest
    iq_payload_t            model_pl[$];
    logic                   model_alu[$];
    logic      [31:0]       rng_state = 32'h1d46;
    int                     errors = 0;

    alu_mdu_iq DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin : watchdog
        #(WATCHDOG);
        $display("timeout: the tests did not finish within %0d time units", WATCHDOG);
        $display("Test failed");
        $finish;
    end

    // --------------------
    // compare tasks

    task check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task check_pr(input pr_t got, input pr_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task check_issue(input issue_t got, input issue_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // --------------------
    // stimulus values

    function automatic logic [31:0] rand_word();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic coin();
        logic [31:0] r;
        r = rand_word();
        return r[0];
    endfunction

    function automatic iq_payload_t random_payload(input logic a_rdy, input logic b_rdy);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = rand_word();
        r2 = rand_word();
        return '{op: r1[OP_W-1:0], a_pr: r1[8 +: PR_W], a_ready: a_rdy,
                 b_pr: r1[16 +: PR_W], b_ready: b_rdy, dest_pr: r1[24 +: PR_W],
                 rob_idx: r2[ROB_W-1:0]};
    endfunction

    // --------------------
    // reference model

    // bank bits pick the bus, upper bits must match
    function automatic logic forwarded(input pr_t pr);
        bank_t bank;
        bank = pr[BANK_W-1:0];
        return wb_valid[bank] && (wb_upper_pr[bank] == pr[PR_W-1:BANK_W]);
    endfunction

    function automatic int oldest(input logic want_alu);
        for (int i = 0; i < model_pl.size(); i++) begin
            if (model_alu[i] == want_alu
                && (model_pl[i].a_ready || forwarded(model_pl[i].a_pr))
                && (model_pl[i].b_ready || forwarded(model_pl[i].b_pr))) begin
                return i;
            end
        end
        return -1;
    endfunction

    task take_entry(input int pos);
        if (pos >= 0) begin
            model_pl.delete(pos);
            model_alu.delete(pos);
        end
    endtask

    task check_pipe(input string name, input int pos, input logic ready, input logic valid,
                    input issue_t got, input logic a_req, input pr_t a_pr,
                    input logic b_req, input pr_t b_pr);
        iq_payload_t p;
        issue_t      exp;
        logic        exp_a;
        logic        exp_b;
        exp_a = 1'b0;
        exp_b = 1'b0;
        check_bit(valid, pos >= 0, {name, " issue valid"});
        if (pos >= 0) begin
            p = model_pl[pos];
            exp = '{op: p.op, a_forward: forwarded(p.a_pr), a_bank: p.a_pr[BANK_W-1:0],
                    b_forward: forwarded(p.b_pr), b_bank: p.b_pr[BANK_W-1:0],
                    dest_pr: p.dest_pr, rob_idx: p.rob_idx};
            check_issue(got, exp, {name, " issue"});
            exp_a = ready && !exp.a_forward;
            exp_b = ready && !exp.b_forward;
            if (exp_a) begin
                check_pr(a_pr, p.a_pr, {name, " read register A"});
            end
            if (exp_b) begin
                check_pr(b_pr, p.b_pr, {name, " read register B"});
            end
        end
        check_bit(a_req, exp_a, {name, " read request A"});
        check_bit(b_req, exp_b, {name, " read request B"});
    endtask

    // runs mid-cycle, then advances the model past the next edge
    task check_cycle();
        logic [WAYS-1:0] grant;
        int              free;
        int              alu_pos;
        int              mdu_pos;
        iq_payload_t     p;
        free = ENTRIES - model_pl.size();
        grant = '0;
        for (int w = 0; w < WAYS; w++) begin
            grant[w] = dispatch_attempt[w] && ($countones(grant) < free);
            check_bit(dispatch_ack[w], grant[w], $sformatf("dispatch ack of way %0d", w));
        end
        alu_pos = oldest(1'b1);
        mdu_pos = oldest(1'b0);
        check_pipe("alu", alu_pos, alu_issue_ready, alu_issue_valid, alu_issue,
                   prf_alu_req_a_valid, prf_alu_req_a_pr, prf_alu_req_b_valid, prf_alu_req_b_pr);
        check_pipe("mdu", mdu_pos, mdu_issue_ready, mdu_issue_valid, mdu_issue,
                   prf_mdu_req_a_valid, prf_mdu_req_a_pr, prf_mdu_req_b_valid, prf_mdu_req_b_pr);
        // wakeup sticks in the stored ready bits
        for (int i = 0; i < model_pl.size(); i++) begin
            p = model_pl[i];
            p.a_ready = p.a_ready | forwarded(p.a_pr);
            p.b_ready = p.b_ready | forwarded(p.b_pr);
            model_pl[i] = p;
        end
        if (!alu_issue_ready) begin
            alu_pos = -1;
        end
        if (!mdu_issue_ready) begin
            mdu_pos = -1;
        end
        // younger one first so the older index still holds
        take_entry(alu_pos > mdu_pos ? alu_pos : mdu_pos);
        take_entry(alu_pos > mdu_pos ? mdu_pos : alu_pos);
        for (int w = 0; w < WAYS; w++) begin
            if (grant[w]) begin
                p = '{op: dispatch_op[w], a_pr: dispatch_a_pr[w], a_ready: dispatch_a_ready[w],
                      b_pr: dispatch_b_pr[w], b_ready: dispatch_b_ready[w],
                      dest_pr: dispatch_dest_pr[w], rob_idx: dispatch_rob_idx[w]};
                model_pl.push_back(p);
                model_alu.push_back(dispatch_is_alu[w]);
            end
        end
    endtask

    // --------------------
    // drive helpers

    task begin_cycle();
        @(posedge CLK);
        dispatch_attempt <= '0;
        wb_valid         <= '0;
    endtask

    task end_cycle();
        @(negedge CLK);
        check_cycle();
    endtask

    task offer(input int w, input logic is_alu, input iq_payload_t p);
        dispatch_attempt[w] <= 1'b1;
        dispatch_is_alu[w]  <= is_alu;
        dispatch_is_mdu[w]  <= ~is_alu;
        dispatch_op[w]      <= p.op;
        dispatch_a_pr[w]    <= p.a_pr;
        dispatch_a_ready[w] <= p.a_ready;
        dispatch_b_pr[w]    <= p.b_pr;
        dispatch_b_ready[w] <= p.b_ready;
        dispatch_dest_pr[w] <= p.dest_pr;
        dispatch_rob_idx[w] <= p.rob_idx;
    endtask

    task drain();
        for (int n = 0; n < 2 * ENTRIES && model_pl.size() > 0; n++) begin
            begin_cycle();
            alu_issue_ready <= 1'b1;
            mdu_issue_ready <= 1'b1;
            end_cycle();
        end
        if (model_pl.size() != 0) begin
            $display("queue did not drain, %0d operations still waiting", model_pl.size());
            errors++;
        end
    endtask

    // --------------------
    // directed tests

    task test_after_reset();
        begin_cycle();
        end_cycle();
        begin_cycle();
        offer(0, 1'b1, random_payload(1'b1, 1'b1));
        offer(1, 1'b0, random_payload(1'b1, 1'b1));
        end_cycle();
        drain();
    endtask

    task test_fill();
        int acks;
        acks = 0;
        for (int n = 0; n < 5; n++) begin
            begin_cycle();
            alu_issue_ready <= 1'b0;
            mdu_issue_ready <= 1'b0;
            offer(0, coin(), random_payload(1'b1, 1'b1));
            offer(1, coin(), random_payload(1'b1, 1'b1));
            end_cycle();
            acks += $countones(dispatch_ack);
        end
        check_bit(acks == ENTRIES, 1'b1, "ack count while filling the queue");
    endtask

    task test_back_pressure();
        for (int n = 0; n < 3; n++) begin
            begin_cycle();
            alu_issue_ready <= 1'b0;
            mdu_issue_ready <= 1'b0;
            end_cycle();
        end
        for (int n = 0; n < ENTRIES; n++) begin
            begin_cycle();
            alu_issue_ready <= 1'b1;
            end_cycle();
        end
        drain();
    endtask

    task test_wakeup();
        iq_payload_t p;
        p = random_payload(1'b0, 1'b1);
        begin_cycle();
        offer(0, 1'b1, p);
        end_cycle();
        repeat (3) begin
            begin_cycle();
            end_cycle();
        end
        begin_cycle();
        wb_valid[p.a_pr[BANK_W-1:0]]    <= 1'b1;
        wb_upper_pr[p.a_pr[BANK_W-1:0]] <= p.a_pr[PR_W-1:BANK_W];
        alu_issue_ready                 <= 1'b0;
        end_cycle();
        check_bit(alu_issue.a_forward, 1'b1, "A forward on the writeback cycle");
        begin_cycle();
        alu_issue_ready <= 1'b1;
        end_cycle();
        check_bit(prf_alu_req_a_valid, 1'b1, "A read request after wakeup");
        drain();
    endtask

    task test_dual_issue();
        for (int n = 0; n < 4; n++) begin
            begin_cycle();
            alu_issue_ready <= 1'b0;
            mdu_issue_ready <= 1'b0;
            offer(0, 1'b1, random_payload(1'b1, 1'b1));
            offer(1, 1'b0, random_payload(1'b1, 1'b1));
            end_cycle();
        end
        for (int n = 0; n < 10; n++) begin
            begin_cycle();
            alu_issue_ready <= 1'b1;
            mdu_issue_ready <= 1'b1;
            offer(0, coin(), random_payload(1'b1, 1'b1));
            offer(1, coin(), random_payload(1'b1, 1'b1));
            end_cycle();
        end
        drain();
    endtask

    initial begin
        nRST             = 1'b0;
        dispatch_attempt = '0;
        dispatch_is_alu  = '0;
        dispatch_is_mdu  = '0;
        dispatch_op      = '0;
        dispatch_a_pr    = '0;
        dispatch_a_ready = '0;
        dispatch_b_pr    = '0;
        dispatch_b_ready = '0;
        dispatch_dest_pr = '0;
        dispatch_rob_idx = '0;
        wb_valid         = '0;
        wb_upper_pr      = '0;
        alu_issue_ready  = 1'b0;
        mdu_issue_ready  = 1'b0;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        test_after_reset();
        test_fill();
        test_back_pressure();
        test_wakeup();
        test_dual_issue();
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
